//--- src/control_unit_pkg.sv
package control_unit_pkg;

	localparam int byte_w = 8;  // Instruction byte width

	// Major opcode in bits 7:4, value 15 decodes as NOP
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_MOV  = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_ROT  = 4'd6,   // RLC, RRC, SETC, CLRC
		OP_STK  = 4'd7,   // PUSH, POP, OUT, IN
		OP_UNA  = 4'd8,   // NOT, NEG, INC, DEC
		OP_BRC  = 4'd9,   // JZ, JN, JC, JV
		OP_LOOP = 4'd10,
		OP_JMP  = 4'd11,  // JMP, CALL, RET, RTI
		OP_EXT  = 4'd12,  // LDM, LDD, STD
		OP_LDI  = 4'd13,
		OP_STI  = 4'd14
	} opcode_e;

	// Group member or branch flag in bits 3:2
	typedef enum logic [1:0] {
		SUB_0 = 2'd0,
		SUB_1 = 2'd1,
		SUB_2 = 2'd2,
		SUB_3 = 2'd3
	} sub_e;

	typedef enum logic [1:0] {
		RD_SP      = 2'd0,  // Stack pointer update
		RD_IN_PORT = 2'd1,
		RD_RDATA   = 2'd2,  // ALU or memory via out mux
		RD_IMM     = 2'd3
	} rdata_sel_e;

	typedef enum logic [1:0] {
		WD_ALU     = 2'd0,
		WD_RD2     = 2'd1,
		WD_PC_NEXT = 2'd2,
		WD_PC      = 2'd3
	} dmem_wd_sel_e;

	typedef enum logic [1:0] {
		DA_ALU    = 2'd0,  // R[ra] through the ALU
		DA_SP     = 2'd1,
		DA_SP_INC = 2'd2,  // Pre-increment SP
		DA_EA     = 2'd3
	} dmem_a_sel_e;

	typedef enum logic [1:0] {
		PC_NEXT      = 2'd0,
		PC_RESET_VEC = 2'd1,  // M[0]
		PC_INTR_VEC  = 2'd2,  // M[1]
		PC_TARGET    = 2'd3
	} pc_sel_e;

	typedef enum logic [1:0] {
		AD_RA     = 2'd0,
		AD_RB     = 2'd1,
		AD_SP     = 2'd2,
		AD_OLD_RB = 2'd3
	} addr_sel_e;

	typedef enum logic [5:0] {
		ALU_NOP  = 6'd0,  ALU_MOV  = 6'd1,  ALU_ADD  = 6'd2,  ALU_SUB  = 6'd3,
		ALU_AND  = 6'd4,  ALU_OR   = 6'd5,  ALU_RLC  = 6'd6,  ALU_RRC  = 6'd7,
		ALU_SETC = 6'd8,  ALU_CLRC = 6'd9,  ALU_PUSH = 6'd10, ALU_POP  = 6'd11,
		ALU_OUT  = 6'd12, ALU_IN   = 6'd13, ALU_NOT  = 6'd14, ALU_NEG  = 6'd15,
		ALU_INC  = 6'd16, ALU_DEC  = 6'd17, ALU_JZ   = 6'd18, ALU_JN   = 6'd19,
		ALU_JC   = 6'd20, ALU_JV   = 6'd21, ALU_LOOP = 6'd22, ALU_PASS_RD2 = 6'd23,
		ALU_CALL = 6'd24, ALU_RET  = 6'd25, ALU_RTI  = 6'd26, ALU_LDM  = 6'd27,
		ALU_LDD  = 6'd28, ALU_STD  = 6'd29, ALU_LDI  = 6'd30, ALU_STI  = 6'd31,
		ALU_INTR = 6'd32
	} alu_op_e;

	typedef struct packed {
		logic v;
		logic c;
		logic n;
		logic z;
	} flags_t;

	typedef struct packed {
		rdata_sel_e   rdata_sel;
		dmem_wd_sel_e dmem_wd_sel;
		dmem_a_sel_e  dmem_a_sel;
		pc_sel_e      pc_sel;
		addr_sel_e    addr_sel;
		logic         out_sel;       // 1 selects ALU, 0 selects memory
		logic         sp_sel;        // 1 increments SP, 0 decrements
		logic         rd2_sel;       // Read old_rb on port 2
		logic         out_port_sel;
		logic         wr_en_dmem;
		logic         rd_en;
		logic         wr_en_regf;
		logic         is_ret;
		logic         sp_inc;
		logic         f_save;
		logic         f_restore;
		logic         branch_taken;
		logic [1:0]   old_rb;
		alu_op_e      alu_op;
	} ctrl_word_t;

	localparam ctrl_word_t CTRL_NOP = '{
		rdata_sel: RD_SP, dmem_wd_sel: WD_ALU, dmem_a_sel: DA_ALU,
		pc_sel: PC_NEXT, addr_sel: AD_RA,
		out_sel: 1'b0, sp_sel: 1'b0, rd2_sel: 1'b0, out_port_sel: 1'b0,
		wr_en_dmem: 1'b0, rd_en: 1'b0, wr_en_regf: 1'b0, is_ret: 1'b0,
		sp_inc: 1'b0, f_save: 1'b0, f_restore: 1'b0, branch_taken: 1'b0,
		old_rb: 2'b00, alu_op: ALU_NOP
	};

	// Same as CTRL_NOP but loads the PC from the reset vector
	localparam ctrl_word_t CTRL_RESET = '{
		rdata_sel: RD_SP, dmem_wd_sel: WD_ALU, dmem_a_sel: DA_ALU,
		pc_sel: PC_RESET_VEC, addr_sel: AD_RA,
		out_sel: 1'b0, sp_sel: 1'b0, rd2_sel: 1'b0, out_port_sel: 1'b0,
		wr_en_dmem: 1'b0, rd_en: 1'b0, wr_en_regf: 1'b0, is_ret: 1'b0,
		sp_inc: 1'b0, f_save: 1'b0, f_restore: 1'b0, branch_taken: 1'b0,
		old_rb: 2'b00, alu_op: ALU_NOP
	};

	typedef enum logic [1:0] {
		S_IDLE   = 2'd0,
		S_SECOND = 2'd1,  // Second byte of LDM/LDD/STD
		S_LOOP   = 2'd2   // LOOP write-back
	} cu_state_e;

endpackage

//--- src/cu_decode.sv
`timescale 1ns/1ns

module cu_decode (
	input  logic [control_unit_pkg::byte_w-1:0] opcode,
	input  control_unit_pkg::flags_t            flags,
	output control_unit_pkg::ctrl_word_t        dec_word,
	output logic                                is_ext,
	output logic                                is_loop
);

	control_unit_pkg::opcode_e op;
	control_unit_pkg::sub_e    sub;
	logic                      br_flag;

	assign op      = control_unit_pkg::opcode_e'(opcode[7:4]);
	assign sub     = control_unit_pkg::sub_e'(opcode[3:2]);
	assign is_ext  = (op == control_unit_pkg::OP_EXT);
	assign is_loop = (op == control_unit_pkg::OP_LOOP);

	// Flag tested by a conditional branch
	always_comb begin
		case (sub)
			control_unit_pkg::SUB_0: br_flag = flags.z;
			control_unit_pkg::SUB_1: br_flag = flags.n;
			control_unit_pkg::SUB_2: br_flag = flags.c;
			default:                 br_flag = flags.v;
		endcase
	end

	always_comb begin
		dec_word = control_unit_pkg::CTRL_NOP;
		case (op)
			control_unit_pkg::OP_MOV, control_unit_pkg::OP_ADD, control_unit_pkg::OP_SUB,
			control_unit_pkg::OP_AND, control_unit_pkg::OP_OR: begin
				// ALU codes 1 to 5 equal the opcode
				dec_word.alu_op     = control_unit_pkg::alu_op_e'({2'b00, opcode[7:4]});
				dec_word.out_sel    = 1'b1;
				dec_word.rdata_sel  = control_unit_pkg::RD_RDATA;
				dec_word.addr_sel   = control_unit_pkg::AD_RA;  // Result to ra
				dec_word.wr_en_regf = 1'b1;
			end
			control_unit_pkg::OP_ROT: begin
				case (sub)
					control_unit_pkg::SUB_0, control_unit_pkg::SUB_1: begin
						dec_word.alu_op     = (sub == control_unit_pkg::SUB_0) ?
							control_unit_pkg::ALU_RLC : control_unit_pkg::ALU_RRC;
						dec_word.out_sel    = 1'b1;
						dec_word.rdata_sel  = control_unit_pkg::RD_RDATA;
						dec_word.addr_sel   = control_unit_pkg::AD_RB;  // Rotate rb in place
						dec_word.wr_en_regf = 1'b1;
					end
					control_unit_pkg::SUB_2: dec_word.alu_op = control_unit_pkg::ALU_SETC;
					default:                 dec_word.alu_op = control_unit_pkg::ALU_CLRC;
				endcase
			end
			control_unit_pkg::OP_STK: begin
				case (sub)
					control_unit_pkg::SUB_0: begin  // PUSH
						dec_word.alu_op      = control_unit_pkg::ALU_PUSH;
						dec_word.dmem_wd_sel = control_unit_pkg::WD_RD2;
						dec_word.dmem_a_sel  = control_unit_pkg::DA_SP;
						dec_word.wr_en_dmem  = 1'b1;
						dec_word.addr_sel    = control_unit_pkg::AD_SP;  // SP--
						dec_word.wr_en_regf  = 1'b1;
					end
					control_unit_pkg::SUB_1: begin  // POP
						dec_word.alu_op     = control_unit_pkg::ALU_POP;
						dec_word.sp_sel     = 1'b1;
						dec_word.sp_inc     = 1'b1;
						dec_word.dmem_a_sel = control_unit_pkg::DA_SP_INC;
						dec_word.rd_en      = 1'b1;
						dec_word.rdata_sel  = control_unit_pkg::RD_RDATA;
						dec_word.addr_sel   = control_unit_pkg::AD_RB;
						dec_word.wr_en_regf = 1'b1;
					end
					control_unit_pkg::SUB_2: begin  // OUT
						dec_word.alu_op       = control_unit_pkg::ALU_OUT;
						dec_word.out_port_sel = 1'b1;
					end
					default: begin  // IN
						dec_word.alu_op     = control_unit_pkg::ALU_IN;
						dec_word.rdata_sel  = control_unit_pkg::RD_IN_PORT;
						dec_word.addr_sel   = control_unit_pkg::AD_RB;
						dec_word.wr_en_regf = 1'b1;
					end
				endcase
			end
			control_unit_pkg::OP_UNA: begin
				case (sub)
					control_unit_pkg::SUB_0: dec_word.alu_op = control_unit_pkg::ALU_NOT;
					control_unit_pkg::SUB_1: dec_word.alu_op = control_unit_pkg::ALU_NEG;
					control_unit_pkg::SUB_2: dec_word.alu_op = control_unit_pkg::ALU_INC;
					default:                 dec_word.alu_op = control_unit_pkg::ALU_DEC;
				endcase
				dec_word.out_sel    = 1'b1;
				dec_word.rdata_sel  = control_unit_pkg::RD_RDATA;
				dec_word.addr_sel   = control_unit_pkg::AD_RB;
				dec_word.wr_en_regf = 1'b1;
			end
			control_unit_pkg::OP_BRC: begin
				if (br_flag) begin
					dec_word.alu_op       = control_unit_pkg::ALU_PASS_RD2;
					dec_word.out_sel      = 1'b1;
					dec_word.pc_sel       = control_unit_pkg::PC_TARGET;
					dec_word.branch_taken = 1'b1;
				end else begin
					// JZ..JV codes follow the flag order
					dec_word.alu_op = control_unit_pkg::alu_op_e'(6'd18 + {4'd0, opcode[3:2]});
				end
			end
			control_unit_pkg::OP_LOOP: begin
				dec_word.alu_op = control_unit_pkg::ALU_LOOP;
				if (flags.z) begin
					dec_word.pc_sel       = control_unit_pkg::PC_TARGET;  // Back to R[rb]
					dec_word.branch_taken = 1'b1;
				end
			end
			control_unit_pkg::OP_JMP: begin
				case (sub)
					control_unit_pkg::SUB_0, control_unit_pkg::SUB_1: begin  // JMP, CALL
						dec_word.out_sel      = 1'b1;
						dec_word.pc_sel       = control_unit_pkg::PC_TARGET;
						dec_word.branch_taken = 1'b1;
						if (sub == control_unit_pkg::SUB_0) begin
							dec_word.alu_op = control_unit_pkg::ALU_PASS_RD2;
						end else begin
							dec_word.alu_op      = control_unit_pkg::ALU_CALL;
							dec_word.dmem_a_sel  = control_unit_pkg::DA_SP;
							dec_word.dmem_wd_sel = control_unit_pkg::WD_PC_NEXT;  // Return addr
							dec_word.addr_sel    = control_unit_pkg::AD_SP;
							dec_word.wr_en_dmem  = 1'b1;
							dec_word.wr_en_regf  = 1'b1;
						end
					end
					default: begin  // RET and RTI pop the PC
						dec_word.alu_op     = (sub == control_unit_pkg::SUB_2) ?
							control_unit_pkg::ALU_RET : control_unit_pkg::ALU_RTI;
						dec_word.f_restore  = (sub == control_unit_pkg::SUB_3);
						dec_word.dmem_a_sel = control_unit_pkg::DA_SP_INC;
						dec_word.pc_sel     = control_unit_pkg::PC_TARGET;
						dec_word.addr_sel   = control_unit_pkg::AD_SP;
						dec_word.rd_en      = 1'b1;
						dec_word.wr_en_regf = 1'b1;
						dec_word.is_ret     = 1'b1;
						dec_word.sp_sel     = 1'b1;
					end
				endcase
			end
			control_unit_pkg::OP_LDI: begin
				dec_word.alu_op     = control_unit_pkg::ALU_LDI;
				dec_word.rdata_sel  = control_unit_pkg::RD_RDATA;
				dec_word.dmem_a_sel = control_unit_pkg::DA_ALU;  // Address R[ra]
				dec_word.addr_sel   = control_unit_pkg::AD_RB;
				dec_word.rd_en      = 1'b1;
				dec_word.wr_en_regf = 1'b1;
			end
			control_unit_pkg::OP_STI: begin
				dec_word.alu_op      = control_unit_pkg::ALU_STI;
				dec_word.dmem_wd_sel = control_unit_pkg::WD_RD2;
				dec_word.dmem_a_sel  = control_unit_pkg::DA_ALU;
				dec_word.wr_en_dmem  = 1'b1;
			end
			default: ;  // NOP, EXT first byte and opcode 15
		endcase
	end

	// No opcode may read and write data memory in one cycle
	a_no_mem_clash: assert final (!(dec_word.wr_en_dmem && dec_word.rd_en));

endmodule

//--- src/cu_ext_decode.sv
`timescale 1ns/1ns

module cu_ext_decode (
	input  control_unit_pkg::cu_state_e         state,
	input  logic [control_unit_pkg::byte_w-1:0] stored,
	output control_unit_pkg::ctrl_word_t        ext_word
);

	control_unit_pkg::sub_e sub;

	assign sub = control_unit_pkg::sub_e'(stored[3:2]);

	always_comb begin
		ext_word = control_unit_pkg::CTRL_NOP;
		case (state)
			control_unit_pkg::S_SECOND: begin
				if (sub != control_unit_pkg::SUB_3) begin
					ext_word.old_rb = stored[1:0];  // Register field of first byte
				end
				case (sub)
					control_unit_pkg::SUB_0: begin  // LDM
						ext_word.alu_op     = control_unit_pkg::ALU_LDM;
						ext_word.rdata_sel  = control_unit_pkg::RD_IMM;
						ext_word.out_sel    = 1'b1;
						ext_word.addr_sel   = control_unit_pkg::AD_OLD_RB;
						ext_word.wr_en_regf = 1'b1;
					end
					control_unit_pkg::SUB_1: begin  // LDD
						ext_word.alu_op     = control_unit_pkg::ALU_LDD;
						ext_word.rdata_sel  = control_unit_pkg::RD_RDATA;
						ext_word.dmem_a_sel = control_unit_pkg::DA_EA;
						ext_word.addr_sel   = control_unit_pkg::AD_OLD_RB;
						ext_word.rd_en      = 1'b1;
						ext_word.wr_en_regf = 1'b1;
					end
					control_unit_pkg::SUB_2: begin  // STD
						ext_word.alu_op      = control_unit_pkg::ALU_STD;
						ext_word.dmem_wd_sel = control_unit_pkg::WD_RD2;
						ext_word.dmem_a_sel  = control_unit_pkg::DA_EA;
						ext_word.rd2_sel     = 1'b1;  // Read old_rb
						ext_word.wr_en_dmem  = 1'b1;
					end
					default: ;
				endcase
			end
			control_unit_pkg::S_LOOP: begin
				// Write the decremented counter back to ra
				ext_word.wr_en_regf = 1'b1;
				ext_word.out_sel    = 1'b1;
				ext_word.rdata_sel  = control_unit_pkg::RD_RDATA;
				ext_word.addr_sel   = control_unit_pkg::AD_RA;
			end
			default: ;
		endcase
	end

endmodule

//--- src/cu_sequencer.sv
`timescale 1ns/1ns

module cu_sequencer (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [control_unit_pkg::byte_w-1:0] opcode,
	input  control_unit_pkg::ctrl_word_t        dec_word,
	input  control_unit_pkg::ctrl_word_t        ext_word,
	input  logic                                is_ext,
	input  logic                                is_loop,
	input  logic                                intr_req,
	output logic                                intr_ack,
	output logic                                stall,
	output control_unit_pkg::cu_state_e         state,
	output logic [control_unit_pkg::byte_w-1:0] stored,
	output control_unit_pkg::ctrl_word_t        ctrl
);

	// Push PC, save flags, jump through M[1]
	localparam control_unit_pkg::ctrl_word_t INTR_WORD = '{
		rdata_sel: control_unit_pkg::RD_SP, dmem_wd_sel: control_unit_pkg::WD_PC,
		dmem_a_sel: control_unit_pkg::DA_SP, pc_sel: control_unit_pkg::PC_INTR_VEC,
		addr_sel: control_unit_pkg::AD_SP,
		out_sel: 1'b0, sp_sel: 1'b0, rd2_sel: 1'b0, out_port_sel: 1'b0,
		wr_en_dmem: 1'b1, rd_en: 1'b0, wr_en_regf: 1'b1, is_ret: 1'b0,
		sp_inc: 1'b0, f_save: 1'b1, f_restore: 1'b0, branch_taken: 1'b0,
		old_rb: 2'b00, alu_op: control_unit_pkg::ALU_INTR
	};

	control_unit_pkg::cu_state_e next_state;
	logic                        intr_take;
	logic                        load_byte;

	assign intr_take = (state == control_unit_pkg::S_IDLE) && intr_req && !intr_ack;

	always_comb begin
		next_state = control_unit_pkg::S_IDLE;
		ctrl       = dec_word;
		stall      = 1'b0;
		load_byte  = 1'b0;
		if (!rst) begin
			ctrl = control_unit_pkg::CTRL_RESET;  // Fetch from reset vector
		end else begin
			case (state)
				control_unit_pkg::S_IDLE: begin
					if (intr_take) begin
						ctrl = INTR_WORD;  // Byte of this cycle is dropped
					end else if (is_ext) begin
						ctrl       = control_unit_pkg::CTRL_NOP;
						stall      = 1'b1;
						load_byte  = 1'b1;
						next_state = control_unit_pkg::S_SECOND;
					end else if (is_loop) begin
						next_state = control_unit_pkg::S_LOOP;
					end
				end
				default: ctrl = ext_word;  // Second cycle of EXT or LOOP
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= control_unit_pkg::S_IDLE;
			intr_ack <= 1'b0;
		end else begin
			state <= next_state;
			if (intr_take) begin
				intr_ack <= 1'b1;
			end else if (!intr_req) begin
				intr_ack <= 1'b0;  // Handshake closes once req drops
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_byte) begin
			stored <= opcode;
		end
	end

	// Two-cycle instructions take exactly two cycles
	a_back_to_idle: assert property (@(posedge clk) disable iff (!rst)
		(state != control_unit_pkg::S_IDLE) |=> (state == control_unit_pkg::S_IDLE));

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
		$rose(intr_ack) |-> $past(intr_req));

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ns

module control_unit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [control_unit_pkg::byte_w-1:0] opcode,
	input  control_unit_pkg::flags_t            flags,
	input  logic                                intr_req,
	output logic                                intr_ack,
	output logic                                stall,
	output control_unit_pkg::ctrl_word_t        ctrl
);

	control_unit_pkg::ctrl_word_t        dec_word;
	control_unit_pkg::ctrl_word_t        ext_word;
	control_unit_pkg::cu_state_e         state;
	logic [control_unit_pkg::byte_w-1:0] stored;
	logic                                is_ext;
	logic                                is_loop;

	cu_sequencer seq0 (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.dec_word (dec_word),
		.ext_word (ext_word),
		.is_ext   (is_ext),
		.is_loop  (is_loop),
		.intr_req (intr_req),
		.intr_ack (intr_ack),
		.stall    (stall),
		.state    (state),
		.stored   (stored),
		.ctrl     (ctrl)
	);

	cu_decode dec0 (
		.opcode   (opcode),
		.flags    (flags),
		.dec_word (dec_word),
		.is_ext   (is_ext),
		.is_loop  (is_loop)
	);

	cu_ext_decode ext0 (
		.state    (state),
		.stored   (stored),
		.ext_word (ext_word)
	);

endmodule

//--- verification/control_unit_tb.sv
`timescale 1ns/1ns

module control_unit_tb;

	localparam int timeout_cycles = 16;

	logic                         clk;
	logic                         rst;
	logic [7:0]                   opcode;
	control_unit_pkg::flags_t     flags;
	logic                         intr_req;
	logic                         intr_ack;
	logic                         stall;
	control_unit_pkg::ctrl_word_t ctrl;

	int          errors;
	int          checks;
	logic [31:0] seed;

	control_unit dut0 (
		.clk      (clk),
		.rst      (rst),
		.opcode   (opcode),
		.flags    (flags),
		.intr_req (intr_req),
		.intr_ack (intr_ack),
		.stall    (stall),
		.ctrl     (ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// ALU or memory result written to a register
	function automatic control_unit_pkg::ctrl_word_t reg_write(
		input control_unit_pkg::alu_op_e    op,
		input control_unit_pkg::rdata_sel_e src,
		input control_unit_pkg::addr_sel_e  dst
	);
		control_unit_pkg::ctrl_word_t w;
		w = control_unit_pkg::CTRL_NOP;
		w.alu_op     = op;
		w.out_sel    = 1'b1;
		w.rdata_sel  = src;
		w.addr_sel   = dst;
		w.wr_en_regf = 1'b1;
		return w;
	endfunction

	// Expected word for one single-byte instruction
	function automatic control_unit_pkg::ctrl_word_t expect_word(
		input logic [7:0]               b,
		input control_unit_pkg::flags_t f
	);
		control_unit_pkg::ctrl_word_t w;
		control_unit_pkg::alu_op_e    alu;
		logic [1:0]                   s;
		logic [5:0]                   s6;
		s  = b[3:2];
		s6 = {4'd0, b[3:2]};
		w  = control_unit_pkg::CTRL_NOP;
		case (b[7:4])
			4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
				case (b[7:4])
					4'd1:    alu = control_unit_pkg::ALU_MOV;
					4'd2:    alu = control_unit_pkg::ALU_ADD;
					4'd3:    alu = control_unit_pkg::ALU_SUB;
					4'd4:    alu = control_unit_pkg::ALU_AND;
					default: alu = control_unit_pkg::ALU_OR;
				endcase
				w = reg_write(alu, control_unit_pkg::RD_RDATA, control_unit_pkg::AD_RA);
			end
			4'd6: begin
				if (s < 2'd2) begin
					w = reg_write(control_unit_pkg::alu_op_e'(6'd6 + s6),
						control_unit_pkg::RD_RDATA, control_unit_pkg::AD_RB);
				end else begin
					w.alu_op = control_unit_pkg::alu_op_e'(6'd6 + s6);  // SETC, CLRC
				end
			end
			4'd7: begin
				w.alu_op = control_unit_pkg::alu_op_e'(6'd10 + s6);
				if (s == 2'd0) begin  // PUSH
					w.dmem_wd_sel = control_unit_pkg::WD_RD2;
					w.dmem_a_sel  = control_unit_pkg::DA_SP;
					w.addr_sel    = control_unit_pkg::AD_SP;
					w.wr_en_dmem  = 1'b1;
					w.wr_en_regf  = 1'b1;
				end else if (s == 2'd1) begin  // POP
					w.sp_sel     = 1'b1;
					w.sp_inc     = 1'b1;
					w.dmem_a_sel = control_unit_pkg::DA_SP_INC;
					w.rd_en      = 1'b1;
					w.rdata_sel  = control_unit_pkg::RD_RDATA;
					w.addr_sel   = control_unit_pkg::AD_RB;
					w.wr_en_regf = 1'b1;
				end else if (s == 2'd2) begin
					w.out_port_sel = 1'b1;
				end else begin  // IN
					w.rdata_sel  = control_unit_pkg::RD_IN_PORT;
					w.addr_sel   = control_unit_pkg::AD_RB;
					w.wr_en_regf = 1'b1;
				end
			end
			4'd8: begin
				w = reg_write(control_unit_pkg::alu_op_e'(6'd14 + s6),
					control_unit_pkg::RD_RDATA, control_unit_pkg::AD_RB);
			end
			4'd9: begin
				if (f[s]) begin  // Flag order z, n, c, v
					w.alu_op       = control_unit_pkg::ALU_PASS_RD2;
					w.out_sel      = 1'b1;
					w.pc_sel       = control_unit_pkg::PC_TARGET;
					w.branch_taken = 1'b1;
				end else begin
					case (s)
						2'd0:    w.alu_op = control_unit_pkg::ALU_JZ;
						2'd1:    w.alu_op = control_unit_pkg::ALU_JN;
						2'd2:    w.alu_op = control_unit_pkg::ALU_JC;
						default: w.alu_op = control_unit_pkg::ALU_JV;
					endcase
				end
			end
			4'd10: begin
				w.alu_op = control_unit_pkg::ALU_LOOP;
				if (f.z) begin
					w.pc_sel       = control_unit_pkg::PC_TARGET;
					w.branch_taken = 1'b1;
				end
			end
			4'd11: begin
				w.pc_sel = control_unit_pkg::PC_TARGET;
				if (s == 2'd0) begin
					w.alu_op       = control_unit_pkg::ALU_PASS_RD2;
					w.out_sel      = 1'b1;
					w.branch_taken = 1'b1;
				end else if (s == 2'd1) begin  // CALL pushes the return address
					w.alu_op       = control_unit_pkg::ALU_CALL;
					w.out_sel      = 1'b1;
					w.branch_taken = 1'b1;
					w.dmem_a_sel   = control_unit_pkg::DA_SP;
					w.dmem_wd_sel  = control_unit_pkg::WD_PC_NEXT;
					w.addr_sel     = control_unit_pkg::AD_SP;
					w.wr_en_dmem   = 1'b1;
					w.wr_en_regf   = 1'b1;
				end else begin
					w.alu_op     = (s == 2'd2) ? control_unit_pkg::ALU_RET :
						control_unit_pkg::ALU_RTI;
					w.f_restore  = (s == 2'd3);
					w.dmem_a_sel = control_unit_pkg::DA_SP_INC;
					w.addr_sel   = control_unit_pkg::AD_SP;
					w.rd_en      = 1'b1;
					w.wr_en_regf = 1'b1;
					w.is_ret     = 1'b1;
					w.sp_sel     = 1'b1;
				end
			end
			4'd13: begin
				w = reg_write(control_unit_pkg::ALU_LDI, control_unit_pkg::RD_RDATA,
					control_unit_pkg::AD_RB);
				w.out_sel = 1'b0;  // Memory data
				w.rd_en   = 1'b1;
			end
			4'd14: begin
				w.alu_op      = control_unit_pkg::ALU_STI;
				w.dmem_wd_sel = control_unit_pkg::WD_RD2;
				w.wr_en_dmem  = 1'b1;
			end
			default: ;
		endcase
		return w;
	endfunction

	// Second-cycle word of LDM, LDD, STD
	function automatic control_unit_pkg::ctrl_word_t ext_expect(input logic [1:0] s,
		input logic [1:0] rb);
		control_unit_pkg::ctrl_word_t w;
		w = control_unit_pkg::CTRL_NOP;
		if (s == 2'd0) begin
			w = reg_write(control_unit_pkg::ALU_LDM, control_unit_pkg::RD_IMM,
				control_unit_pkg::AD_OLD_RB);
		end else if (s == 2'd1) begin
			w = reg_write(control_unit_pkg::ALU_LDD, control_unit_pkg::RD_RDATA,
				control_unit_pkg::AD_OLD_RB);
			w.out_sel    = 1'b0;
			w.rd_en      = 1'b1;
			w.dmem_a_sel = control_unit_pkg::DA_EA;
		end else if (s == 2'd2) begin
			w.alu_op      = control_unit_pkg::ALU_STD;
			w.dmem_wd_sel = control_unit_pkg::WD_RD2;
			w.dmem_a_sel  = control_unit_pkg::DA_EA;
			w.rd2_sel     = 1'b1;
			w.wr_en_dmem  = 1'b1;
		end
		if (s != 2'd3) begin
			w.old_rb = rb;
		end
		return w;
	endfunction

	function automatic control_unit_pkg::ctrl_word_t intr_expect();
		control_unit_pkg::ctrl_word_t w;
		w = control_unit_pkg::CTRL_NOP;
		w.alu_op      = control_unit_pkg::ALU_INTR;
		w.f_save      = 1'b1;
		w.wr_en_dmem  = 1'b1;
		w.wr_en_regf  = 1'b1;
		w.pc_sel      = control_unit_pkg::PC_INTR_VEC;
		w.dmem_wd_sel = control_unit_pkg::WD_PC;
		w.dmem_a_sel  = control_unit_pkg::DA_SP;
		w.addr_sel    = control_unit_pkg::AD_SP;
		return w;
	endfunction

	task automatic check_ctrl(input string name, input control_unit_pkg::ctrl_word_t exp,
		input control_unit_pkg::ctrl_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_state(input string name, input control_unit_pkg::cu_state_e exp,
		input control_unit_pkg::cu_state_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
		end
	endtask

	// One byte per cycle, sampled at the falling edge
	task automatic present(input logic [7:0] b, input control_unit_pkg::flags_t f,
		input logic req);
		@(posedge clk);
		opcode   <= b;
		flags    <= f;
		intr_req <= req;
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	// Holds intr_req at the level that intr_ack should follow
	task automatic wait_ack(input logic level, input string name);
		int n;
		n = 0;
		while (intr_ack !== level && n < timeout_cycles) begin
			present(8'h00, 4'h0, level);
			n++;
		end
		if (intr_ack !== level) begin
			errors++;
			$display("%s: intr_ack did not reach %b in %0d cycles", name, level, n);
		end
	endtask

	task automatic test_reset();
		int e;
		e = errors;
		repeat (8) begin
			@(negedge clk);
			check_ctrl("reset word", control_unit_pkg::CTRL_RESET, ctrl);
			check_bit("reset stall", 1'b0, stall);
			check_bit("reset intr_ack", 1'b0, intr_ack);
		end
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_state("after reset", control_unit_pkg::S_IDLE, dut0.state);
		check_ctrl("after reset", control_unit_pkg::CTRL_NOP, ctrl);
		check_bit("after reset stall", 1'b0, stall);
		check_bit("after reset intr_ack", 1'b0, intr_ack);
		finish_test("reset", e);
	endtask

	task automatic test_single();
		int                       e;
		int                       op;
		int                       s;
		logic [31:0]              r;
		logic [7:0]               b;
		control_unit_pkg::flags_t f;
		e = errors;
		for (op = 0; op < 16; op++) begin
			if (op == 10 || op == 12) begin
				continue;  // Two-cycle groups have their own tests
			end
			for (s = 0; s < 4; s++) begin
				r = next_rand();
				b = {op[3:0], s[1:0], r[1:0]};
				f = r[7:4];
				present(b, f, 1'b0);
				check_ctrl($sformatf("opcode %h", b), expect_word(b, f), ctrl);
			end
		end
		finish_test("single byte", e);
	endtask

	task automatic test_branch();
		int                       e;
		int                       s;
		logic [7:0]               b;
		control_unit_pkg::flags_t f;
		e = errors;
		for (s = 0; s < 4; s++) begin
			b = {4'h9, s[1:0], 2'b01};
			f = 4'b0001 << s;
			present(b, f, 1'b0);
			check_ctrl($sformatf("branch %h taken", b), expect_word(b, f), ctrl);
			check_bit("branch_taken set", 1'b1, ctrl.branch_taken);
			f = ~(4'b0001 << s);
			present(b, f, 1'b0);
			check_ctrl($sformatf("branch %h not taken", b), expect_word(b, f), ctrl);
			check_bit("branch_taken clear", 1'b0, ctrl.branch_taken);
		end
		finish_test("branch", e);
	endtask

	task automatic test_ext();
		int          e;
		int          s;
		logic [31:0] r;
		e = errors;
		for (s = 0; s < 4; s++) begin
			r = next_rand();
			present({4'hC, s[1:0], r[1:0]}, r[7:4], 1'b0);
			check_ctrl("ext first byte", control_unit_pkg::CTRL_NOP, ctrl);
			check_bit("ext first stall", 1'b1, stall);
			present(r[23:16], r[11:8], 1'b0);  // Byte is ignored
			check_state("ext second", control_unit_pkg::S_SECOND, dut0.state);
			check_ctrl($sformatf("ext sub %0d", s), ext_expect(s[1:0], r[1:0]), ctrl);
			check_bit("ext second stall", 1'b0, stall);
		end
		present(8'h00, 4'h0, 1'b0);
		check_state("after ext", control_unit_pkg::S_IDLE, dut0.state);
		check_ctrl("after ext", control_unit_pkg::CTRL_NOP, ctrl);
		finish_test("two byte", e);
	endtask

	task automatic test_loop();
		int                       e;
		int                       z;
		logic [31:0]              r;
		logic [7:0]               b;
		control_unit_pkg::flags_t f;
		e = errors;
		for (z = 0; z < 2; z++) begin
			r = next_rand();
			b = {4'hA, r[3:0]};
			f = {r[7:5], z[0]};
			present(b, f, 1'b0);
			check_ctrl("loop first", expect_word(b, f), ctrl);
			check_bit("loop taken", z[0], ctrl.branch_taken);
			present(r[15:8], r[19:16], 1'b0);
			check_state("loop second", control_unit_pkg::S_LOOP, dut0.state);
			check_ctrl("loop write-back", reg_write(control_unit_pkg::ALU_NOP,
				control_unit_pkg::RD_RDATA, control_unit_pkg::AD_RA), ctrl);
			present(8'h24, f, 1'b0);  // ADD right after
			check_state("after loop", control_unit_pkg::S_IDLE, dut0.state);
			check_ctrl("after loop", expect_word(8'h24, f), ctrl);
		end
		finish_test("loop", e);
	endtask

	task automatic test_intr();
		int e;
		e = errors;
		present(8'h24, 4'h0, 1'b1);
		check_ctrl("intr entry", intr_expect(), ctrl);
		check_bit("intr_ack before entry edge", 1'b0, intr_ack);
		wait_ack(1'b1, "intr rise");
		check_ctrl("intr after entry", control_unit_pkg::CTRL_NOP, ctrl);
		repeat (3) begin
			present(8'h00, 4'h0, 1'b1);
			check_ctrl("intr held", control_unit_pkg::CTRL_NOP, ctrl);
			check_bit("intr_ack held", 1'b1, intr_ack);
		end
		wait_ack(1'b0, "intr fall");
		check_ctrl("intr closed", control_unit_pkg::CTRL_NOP, ctrl);
		finish_test("interrupt", e);
	endtask

	initial begin
		rst      = 1'b0;
		opcode   = 8'h00;
		flags    = 4'h0;
		intr_req = 1'b0;
		errors   = 0;
		checks   = 0;
		seed     = 32'h006877a7;
		test_reset();
		test_single();
		test_branch();
		test_ext();
		test_loop();
		test_intr();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- control_unit.f
src/control_unit_pkg.sv
src/cu_decode.sv
src/cu_ext_decode.sv
src/cu_sequencer.sv
src/control_unit.sv
verification/control_unit_tb.sv
